/* include/game_defines.svh */
// 800x600 at 40 MHz only; all timing values are 11-bit and colours are 12-bit 4:4:4
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// ============================================================
// raster timing, horizontal in pixels
// ============================================================
`define H_VISIBLE     11'd800
`define H_TOTAL       11'd1056
`define H_SYNC_START  11'd840
`define H_SYNC_END    11'd968

// raster timing, vertical in lines
`define V_VISIBLE     11'd600
`define V_TOTAL       11'd628
`define V_SYNC_START  11'd601
`define V_SYNC_END    11'd605

// ============================================================
// screen and box colours
// ============================================================
`define START_RGB     12'h2_4_8
`define LEVEL_RGB     12'h1_6_2
`define FINISH_RGB    12'h8_1_1
`define CURSOR_RGB    12'hf_f_f
`define PLAYER_RGB    12'hf_c_0

// box sizes in pixels
`define CURSOR_W      11'd16
`define CURSOR_H      11'd16
`define PLAYER_W      11'd48
`define PLAYER_H      11'd64

`endif

/* rtl/draw_background.sv */
// one cycle latency; paints every pixel including blanking, the selector does the blanking
`timescale 1ns/1ps

module draw_background import game_pkg::*; #(
    parameter rgb_t BG_RGB = 12'h000
) (
    input  logic clk_40,
    input  logic rst,
    input  vga_t vga_in,
    output vga_t vga_out
);

    vga_t pixel_nxt;

    // ============================================================
    // colour replacement
    // ============================================================
    always_comb begin
        pixel_nxt     = vga_in;                                 // counts and flags unchanged
        pixel_nxt.rgb = BG_RGB;
    end

    // ============================================================
    // pipeline register
    // ============================================================
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pixel_nxt;
        end
    end

endmodule

/* rtl/draw_rect.sv */
// one cycle latency; a box past the visible edge spills into blanking and is hidden later
`timescale 1ns/1ps

module draw_rect import game_pkg::*; #(
    parameter logic [10:0] RECT_W   = 11'd16,
    parameter logic [10:0] RECT_H   = 11'd16,
    parameter rgb_t        RECT_RGB = 12'hfff
) (
    input  logic clk_40,
    input  logic rst,
    input  vga_t vga_in,
    input  pos_t rect_pos,
    output vga_t vga_out
);

    // ============================================================
    // box bounds
    // ============================================================
    logic [11:0] x_end;                                         // one bit wider, no wrap
    logic [11:0] y_end;
    logic        in_x;
    logic        in_y;
    vga_t        pixel_nxt;

    always_comb begin
        x_end = {1'b0, rect_pos.x} + {1'b0, RECT_W};
        y_end = {1'b0, rect_pos.y} + {1'b0, RECT_H};
        in_x  = (vga_in.hcount >= rect_pos.x) && ({1'b0, vga_in.hcount} < x_end);
        in_y  = (vga_in.vcount >= rect_pos.y) && ({1'b0, vga_in.vcount} < y_end);
    end

    always_comb begin
        pixel_nxt = vga_in;
        if (in_x && in_y) begin
            pixel_nxt.rgb = RECT_RGB;                           // inside the box
        end
    end

    // ============================================================
    // pipeline register
    // ============================================================
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pixel_nxt;
        end
    end

endmodule

/* rtl/game_pkg.sv */
// types only; the undefined fourth state code is handled by the selector as START
package game_pkg;

    // ============================================================
    // colour and pixel stream
    // ============================================================
    typedef logic [11:0] rgb_t;             // r[11:8] g[7:4] b[3:0]

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        rgb_t        rgb;
    } vga_t;                                // 38 bits

    // ============================================================
    // game control
    // ============================================================
    typedef enum logic [1:0] {
        START   = 2'd0,
        LEVEL_1 = 2'd1,
        FINISH  = 2'd2
    } g_state;                              // 2'd3 unused

    // top left corner of a box on screen
    typedef struct packed {
        logic [10:0] x;
        logic [10:0] y;
    } pos_t;

endpackage

/* rtl/game_top.sv */
// positions are sampled every cycle, so change them only in vertical blanking
`timescale 1ns/1ps

`include "game_defines.svh"

module game_top import game_pkg::*; (
    input  logic   clk_40,
    input  logic   rst,
    input  g_state game_state,
    input  pos_t   mouse_pos,
    input  pos_t   player_pos,
    output vga_t   vga
);

    vga_t timing;
    vga_t menu_bg;
    vga_t menu_out;
    vga_t level_bg;
    vga_t level_out;
    vga_t finish_out;

    vga_timing u_vga_timing (
        .clk_40 (clk_40),
        .rst    (rst),
        .timing (timing)
    );

    // ============================================================
    // start screen with cursor
    // ============================================================
    draw_background #(.BG_RGB(`START_RGB)) u_start_bg (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_in  (timing),
        .vga_out (menu_bg)
    );

    draw_rect #(
        .RECT_W   (`CURSOR_W),
        .RECT_H   (`CURSOR_H),
        .RECT_RGB (`CURSOR_RGB)
    ) u_cursor (
        .clk_40   (clk_40),
        .rst      (rst),
        .vga_in   (menu_bg),
        .rect_pos (mouse_pos),
        .vga_out  (menu_out)
    );

    // ============================================================
    // level screen with player
    // ============================================================
    draw_background #(.BG_RGB(`LEVEL_RGB)) u_level_bg (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_in  (timing),
        .vga_out (level_bg)
    );

    draw_rect #(
        .RECT_W   (`PLAYER_W),
        .RECT_H   (`PLAYER_H),
        .RECT_RGB (`PLAYER_RGB)
    ) u_player (
        .clk_40   (clk_40),
        .rst      (rst),
        .vga_in   (level_bg),
        .rect_pos (player_pos),
        .vga_out  (level_out)
    );

    // ============================================================
    // finish screen and selector
    // ============================================================
    draw_background #(.BG_RGB(`FINISH_RGB)) u_finish_bg (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_in  (timing),
        .vga_out (finish_out)
    );

    start_game u_start_game (
        .clk_40     (clk_40),
        .rst        (rst),
        .game_state (game_state),
        .menu_in    (menu_out),
        .level_in   (level_out),
        .finish_in  (finish_out),
        .vga_out    (vga)
    );

endmodule

/* rtl/start_game.sv */
// expects two-stage menu and level paths and a one-stage finish path; code 2'd3 shows START
`timescale 1ns/1ps

module start_game import game_pkg::*; (
    input  logic   clk_40,
    input  logic   rst,
    input  g_state game_state,
    input  vga_t   menu_in,
    input  vga_t   level_in,
    input  vga_t   finish_in,
    output vga_t   vga_out
);

    // ============================================================
    // latency alignment
    // ============================================================
    vga_t finish_dly;                                           // finish path is one stage short

    always_ff @(posedge clk_40) begin
        finish_dly <= finish_in;
    end

    // ============================================================
    // screen select
    // ============================================================
    vga_t selected;
    vga_t pixel_nxt;

    always_comb begin
        case (game_state)
            LEVEL_1: selected = level_in;
            FINISH:  selected = finish_dly;
            default: selected = menu_in;                        // START and the spare code
        endcase
    end

    // colour must be black outside the visible area
    always_comb begin
        pixel_nxt = selected;
        if (selected.hblnk || selected.vblnk) begin
            pixel_nxt.rgb = '0;
        end
    end

    // ============================================================
    // output register
    // ============================================================
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pixel_nxt;
        end
    end

endmodule

/* rtl/vga_timing.sv */
// free-running 800x600 raster; rgb is always zero and all fields are zero after reset
`timescale 1ns/1ps

`include "game_defines.svh"

module vga_timing import game_pkg::*; (
    input  logic clk_40,
    input  logic rst,
    output vga_t timing
);

    // ============================================================
    // next counter values
    // ============================================================
    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    logic        hsync_nxt;
    logic        vsync_nxt;
    logic        hblnk_nxt;
    logic        vblnk_nxt;

    always_comb begin
        if (timing.hcount == `H_TOTAL - 11'd1) begin
            hcount_nxt = '0;                                    // end of line
            if (timing.vcount == `V_TOTAL - 11'd1) begin
                vcount_nxt = '0;                                // end of frame
            end else begin
                vcount_nxt = timing.vcount + 11'd1;
            end
        end else begin
            hcount_nxt = timing.hcount + 11'd1;
            vcount_nxt = timing.vcount;
        end
    end

    // flags follow the next counts so they leave the register aligned
    always_comb begin
        hsync_nxt = (hcount_nxt >= `H_SYNC_START) && (hcount_nxt < `H_SYNC_END);
        vsync_nxt = (vcount_nxt >= `V_SYNC_START) && (vcount_nxt < `V_SYNC_END);
        hblnk_nxt = (hcount_nxt >= `H_VISIBLE);
        vblnk_nxt = (vcount_nxt >= `V_VISIBLE);
    end

    // ============================================================
    // output register
    // ============================================================
    always_ff @(posedge clk_40) begin
        if (rst) begin
            timing <= '0;
        end else begin
            timing.hcount <= hcount_nxt;
            timing.vcount <= vcount_nxt;
            timing.hsync  <= hsync_nxt;
            timing.vsync  <= vsync_nxt;
            timing.hblnk  <= hblnk_nxt;
            timing.vblnk  <= vblnk_nxt;
            timing.rgb    <= '0;                                // colour added downstream
        end
    end

endmodule

/* src.f */
+incdir+include
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/draw_background.sv
rtl/draw_rect.sv
rtl/start_game.sv
rtl/game_top.sv
tb/game_properties.sv
tb/game_tb.sv

/* tb/game_properties.sv */
// bound into start_game; needs a reset of at least three cycles before any check counts
`timescale 1ns/1ps

`include "game_defines.svh"

module game_properties import game_pkg::*; (
    input logic   clk_40,
    input logic   rst,
    input g_state game_state,
    input vga_t   vga_out
);

    int unsigned error_count;                                   // read by the testbench

    initial begin
        error_count = 0;
    end

    // ============================================================
    // reset and blanking
    // ============================================================
    reset_clears_output: assert property (@(posedge clk_40) rst |=> vga_out == '0)
        else begin
            $error("vga_out not zero after a reset cycle");
            error_count++;
        end

    blank_is_black: assert property (@(posedge clk_40) disable iff (rst)
        (vga_out.hblnk || vga_out.vblnk) |-> vga_out.rgb == '0)
        else begin
            $error("rgb not black during blanking");
            error_count++;
        end

    // ============================================================
    // raster and state behaviour
    // ============================================================
    hcount_steps: assert property (@(posedge clk_40) disable iff (rst)
        (vga_out.hcount == $past(vga_out.hcount) + 11'd1) || (vga_out.hcount == '0))
        else begin
            $error("hcount neither advanced by one nor wrapped");
            error_count++;
        end

    // output follows the state of one cycle earlier
    finish_colour: assert property (@(posedge clk_40) disable iff (rst)
        (!$past(rst) && !$past(rst, 2) && !$past(rst, 3) && $past(game_state) == FINISH
            && !vga_out.hblnk && !vga_out.vblnk) |-> vga_out.rgb == `FINISH_RGB)
        else begin
            $error("finish screen colour wrong");
            error_count++;
        end

endmodule

bind start_game game_properties props_inst (
    .clk_40     (clk_40),
    .rst        (rst),
    .game_state (game_state),
    .vga_out    (vga_out)
);

/* tb/game_tb.sv */
// 4 ns clock, positions change only in output vertical blanking, run covers about six frames
`timescale 1ns/1ps

`include "game_defines.svh"

module game_tb import game_pkg::*;;

    localparam int     HOLD          = 0;
    localparam int     HOP_STATE     = 1;
    localparam int     HOP_MOUSE     = 2;
    localparam longint FRAME_CYCLES  = longint'(`H_TOTAL) * longint'(`V_TOTAL);
    localparam longint WATCHDOG_NS   = (6 * FRAME_CYCLES + 4096) * 4;

    logic        clk_40;
    logic        rst;
    g_state      game_state;
    pos_t        mouse_pos;
    pos_t        player_pos;
    vga_t        vga;
    logic [15:0] lfsr_state;
    string       test_name;
    g_state      state_prev;                                    // state the output follows
    g_state      origin_state;                                  // state behind the first pixel
    g_state      shown_state;                                   // screen the output showed there
    int          frames_seen;

    game_top game_top_inst (
        .clk_40     (clk_40),
        .rst        (rst),
        .game_state (game_state),
        .mouse_pos  (mouse_pos),
        .player_pos (player_pos),
        .vga        (vga)
    );

    always #2 clk_40 = ~clk_40;

    // ============================================================
    // random source and reference model
    // ============================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[14:0], lfsr_state[0]};
        end
    endtask

    task automatic draw_pos(output pos_t p);
        logic [15:0] bits;
        take_bits(10, bits);
        p.x = {1'b0, bits[9:0]};                                // may land in blanking
        take_bits(9, bits);
        p.y = {2'b0, bits[8:0]} + 11'd100;
    endtask

    // box straddles the lower right corner of the visible area
    task automatic draw_edge_pos(output pos_t p);
        logic [15:0] bits;
        take_bits(5, bits);
        p.x = `H_VISIBLE - 11'd16 + {6'd0, bits[4:0]};
        take_bits(5, bits);
        p.y = `V_VISIBLE - 11'd16 + {6'd0, bits[4:0]};
    endtask

    function automatic bit in_box(input logic [10:0] h, input logic [10:0] v, input pos_t p,
                                  input int w, input int ht);
        return (h >= p.x) && (int'(h) < int'(p.x) + w) && (v >= p.y) && (int'(v) < int'(p.y) + ht);
    endfunction

    function automatic rgb_t expected_rgb(input logic [10:0] h, input logic [10:0] v,
                                          input g_state st, input pos_t mouse, input pos_t player);
        if (h >= `H_VISIBLE || v >= `V_VISIBLE) begin
            return '0;
        end
        case (st)
            LEVEL_1: return in_box(h, v, player, `PLAYER_W, `PLAYER_H) ? `PLAYER_RGB : `LEVEL_RGB;
            FINISH:  return `FINISH_RGB;
            default: return in_box(h, v, mouse, `CURSOR_W, `CURSOR_H) ? `CURSOR_RGB : `START_RGB;
        endcase
    endfunction

    function automatic logic [3:0] expected_flags(input logic [10:0] h, input logic [10:0] v);
        return {h >= `H_SYNC_START && h < `H_SYNC_END, v >= `V_SYNC_START && v < `V_SYNC_END,
                h >= `H_VISIBLE, v >= `V_VISIBLE};              // hsync vsync hblnk vblnk
    endfunction

    // screen a state is expected to show, the spare code shows the start screen
    function automatic g_state screen_of(input g_state st);
        return (st == LEVEL_1 || st == FINISH) ? st : START;
    endfunction

    // screen named by a background colour
    function automatic g_state screen_from_rgb(input rgb_t c);
        case (c)
            `LEVEL_RGB:  return LEVEL_1;
            `FINISH_RGB: return FINISH;
            default:     return START;
        endcase
    endfunction

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_vga(input string name, input vga_t exp, input vga_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_sync(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input logic [10:0] exp, input logic [10:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_state_count(input string name, input g_state exp_state,
                                     input g_state act_state, input int exp_frames,
                                     input int act_frames);
        if (act_state !== exp_state || act_frames != exp_frames) begin
            $display("[FAIL] %s: expected state %0d frames %0d, actual state %0d frames %0d",
                     name, exp_state, exp_frames, act_state, act_frames);
            stop_on_failure();
        end
    endtask

    // ============================================================
    // output checker, samples on the falling edge
    // ============================================================
    initial begin : compare_outputs
        int          valid_count;
        logic [10:0] prev_hcount;
        logic [10:0] h;
        logic [10:0] v;
        valid_count  = 0;
        prev_hcount  = '0;
        state_prev   = START;
        origin_state = START;
        shown_state  = START;
        frames_seen  = 0;
        @(posedge clk_40);
        forever begin
            @(negedge clk_40);
            h = vga.hcount;
            v = vga.vcount;
            if (rst || valid_count <= 1) begin
                check_vga("reset", '0, vga);
            end
            if (!rst) begin
                if (valid_count >= 3) begin                     // pipeline filled
                    check_sync("raster flags", expected_flags(h, v),
                               {vga.hsync, vga.vsync, vga.hblnk, vga.vblnk});
                    check_rgb(test_name, expected_rgb(h, v, state_prev, mouse_pos, player_pos),
                              vga.rgb);
                    if (h == 11'd0 && v == 11'd0) begin
                        origin_state = state_prev;
                        shown_state  = screen_from_rgb(vga.rgb);
                    end
                    if (h == 11'd0 && v == `V_VISIBLE) begin
                        frames_seen++;
                    end
                end
                if (valid_count >= 4) begin
                    check_count("hcount step",
                                (prev_hcount == `H_TOTAL - 11'd1) ? 11'd0 : prev_hcount + 11'd1, h);
                end
                valid_count++;
            end
            prev_hcount = h;
            state_prev  = game_state;
        end
    end

    always @(game_top_inst.u_start_game.props_inst.error_count) begin
        if (game_top_inst.u_start_game.props_inst.error_count != 0) begin
            $display("a bound assertion on the selector failed");
            stop_on_failure();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired: the raster did not reach the last frame boundary in time");
        stop_on_failure();
    end

    // ============================================================
    // stimulus
    // ============================================================
    // runs until the output reaches the start of vertical blanking
    task automatic run_frame(input int mode);
        int          cycles;
        logic [15:0] bits;
        pos_t        p;
        cycles = 0;
        do begin
            @(posedge clk_40);
            #1;
            cycles++;
            if (cycles % 64 == 0 && mode == HOP_STATE) begin
                take_bits(2, bits);
                game_state = g_state'(bits[1:0]);
            end else if (cycles % 64 == 0 && mode == HOP_MOUSE) begin
                draw_pos(p);
                mouse_pos = p;                                  // unused on the level screen
            end
        end while (!(vga.hcount == 11'd0 && vga.vcount == `V_VISIBLE));
    endtask

    initial begin : stimulus
        pos_t p;
        int   start_frames;
        clk_40     = 1'b0;
        rst        = 1'b1;
        game_state = START;
        mouse_pos  = '0;
        player_pos = '0;
        lfsr_state = 16'd25774;
        test_name  = "reset";
        repeat (4) @(posedge clk_40);
        #1;
        rst = 1'b0;
        run_frame(HOLD);

        test_name    = "start screen";
        start_frames = frames_seen;
        draw_edge_pos(p);
        mouse_pos = p;
        draw_pos(p);
        player_pos = p;
        run_frame(HOLD);
        check_state_count(test_name, START, shown_state, 1, frames_seen - start_frames);

        test_name    = "level screen";
        start_frames = frames_seen;
        game_state   = LEVEL_1;
        draw_pos(p);
        player_pos = p;
        run_frame(HOP_MOUSE);
        check_state_count(test_name, LEVEL_1, shown_state, 1, frames_seen - start_frames);

        test_name    = "finish screen";
        start_frames = frames_seen;
        game_state   = FINISH;
        run_frame(HOLD);
        check_state_count(test_name, FINISH, shown_state, 1, frames_seen - start_frames);

        test_name    = "undefined state";
        start_frames = frames_seen;
        game_state   = g_state'(2'd3);
        draw_pos(p);
        mouse_pos = p;
        run_frame(HOLD);
        check_state_count(test_name, START, shown_state, 1, frames_seen - start_frames);

        test_name    = "mid-frame state changes";
        start_frames = frames_seen;
        run_frame(HOP_STATE);
        check_state_count(test_name, screen_of(origin_state), shown_state, 1,
                          frames_seen - start_frames);

        if (game_top_inst.u_start_game.props_inst.error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("the bound assertions reported errors");
            stop_on_failure();
        end
    end

endmodule
